//--- common/histPkg.sv
package histPkg;

    // raw sample and histogram geometry
    localparam int SampleWidth = 10;
    localparam int BinBits     = 6;
    localparam int NumBins     = 1 << BinBits;   // 64 bins, fixed
    localparam int CountWidth  = 21;             // window length bounds every count
    localparam int HitWidth    = 16;             // per-window hit and reject totals

    typedef logic [SampleWidth-1:0] sample_t;
    typedef logic [BinBits-1:0]     bin_t;
    typedef logic [CountWidth-1:0]  count_t;
    typedef logic [HitWidth-1:0]    hit_t;

    // mapper output, 8 bits
    typedef struct packed {
        logic valid;     // a sample arrived
        logic inRange;   // sample landed inside the 64 bins
        bin_t bin;
    } mapped_t;

    // one histogram update, 27 bits
    typedef struct packed {
        bin_t   bin;
        count_t count;   // the bin's new count
    } binUpdate_t;

    // once-per-window summary, 59 bits
    typedef struct packed {
        bin_t   peakBin;
        count_t peakCount;
        hit_t   hits;
        hit_t   rejected;
    } windowResult_t;

endpackage

//--- src/binMapper.sv
`timescale 1ns/100ps

module binMapper #(
    parameter int BinOffset = 16,   // lowest accepted sample value
    parameter int BinShift  = 2     // log2 of bin width in sample units
) (
    input  logic             clk,
    input  logic             res,
    input  logic             sampleValid,
    input  histPkg::sample_t sample,
    output histPkg::mapped_t mapped
);
    import histPkg::*;

    localparam sample_t Offset  = sample_t'(BinOffset);
    localparam sample_t LastBin = sample_t'(NumBins - 1);

    sample_t delta;
    sample_t scaled;
    logic    below;
    mapped_t mappedNext;

    assign below  = (sample < Offset);   // left of bin 0
    assign delta  = sample - Offset;     // wraps when below, flagged anyway
    assign scaled = delta >> BinShift;

    always_comb begin
        mappedNext.valid   = sampleValid;
        // reject below the offset and past the 64th bin
        mappedNext.inRange = !below && (scaled <= LastBin);
        mappedNext.bin     = scaled[BinBits-1:0];
    end

    // one cycle of latency, sample to mapped
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            mapped <= '0;
        end else begin
            mapped <= mappedNext;
        end
    end

endmodule

//--- histBuilder/histBuilder.sv
`timescale 1ns/100ps

module histBuilder #(
    parameter int AcqLength = 64   // window length in cycles
) (
    input  logic                clk,
    input  logic                res,
    input  histPkg::mapped_t    mapped,
    output logic                updValid,
    output histPkg::binUpdate_t upd,
    output logic                rejValid,
    output logic                windowEnd
);
    import histPkg::*;

    // counter just wide enough for AcqLength-1
    localparam int WinBits = (AcqLength > 1) ? $clog2(AcqLength) : 1;
    localparam logic [WinBits-1:0] LastCycle = WinBits'(AcqLength - 1);

    count_t             binCount [NumBins];   // one register per bin
    logic [NumBins-1:0] touched;              // bin already hit this window
    logic [WinBits-1:0] winCnt;

    logic   hit;
    logic   reject;
    logic   lastCycle;
    count_t newCount;

    assign hit       = mapped.valid && mapped.inRange;
    assign reject    = mapped.valid && !mapped.inRange;
    assign lastCycle = (winCnt == LastCycle);

    // Lazy clear. A bin whose touched bit is down holds a stale count
    // from an earlier window, so its first hit restarts at 1 instead of
    // reading the register.
    assign newCount = touched[mapped.bin] ? binCount[mapped.bin] + 1'b1
                                          : count_t'(1);

    // window counter, strobes and touched bits
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            winCnt    <= '0;
            touched   <= '0;
            updValid  <= 1'b0;
            rejValid  <= 1'b0;
            windowEnd <= 1'b0;
        end else begin
            updValid  <= hit;
            rejValid  <= reject;
            windowEnd <= lastCycle;
            if (lastCycle) begin
                winCnt  <= '0;
                touched <= '0;   // wins over a hit on this edge
            end else begin
                winCnt <= winCnt + 1'b1;
                if (hit) begin
                    touched[mapped.bin] <= 1'b1;
                end
            end
        end
    end

    // count store and update payload, qualified by updValid
    always_ff @(posedge clk) begin
        if (hit) begin
            binCount[mapped.bin] <= newCount;
            upd.bin              <= mapped.bin;
            upd.count            <= newCount;
        end
    end

endmodule

//--- histBuilder/peakTracker.sv
`timescale 1ns/100ps

module peakTracker (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   updValid,
    input  histPkg::binUpdate_t    upd,
    input  logic                   rejValid,
    input  logic                   windowEnd,
    output logic                   resultValid,
    output histPkg::windowResult_t result
);
    import histPkg::*;

    windowResult_t acc;       // running totals of the open window
    windowResult_t accNext;   // acc with this cycle's strobes folded in

    always_comb begin
        accNext = acc;
        if (updValid) begin
            accNext.hits = acc.hits + 1'b1;
            // strictly greater, so the first bin to reach a count keeps the peak
            if (upd.count > acc.peakCount) begin
                accNext.peakBin   = upd.bin;
                accNext.peakCount = upd.count;
            end
        end
        if (rejValid) begin
            accNext.rejected = acc.rejected + 1'b1;
        end
    end

    // accumulators restart from bin 0, count 0 at every window end
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acc         <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= windowEnd;
            if (windowEnd) begin
                acc <= '0;
            end else begin
                acc <= accNext;
            end
        end
    end

    // update on the window-end cycle still counts in the ending window
    always_ff @(posedge clk) begin
        if (windowEnd) begin
            result <= accNext;
        end
    end

endmodule

//--- src/histTop.sv
`timescale 1ns/100ps

module histTop #(
    parameter int AcqLength = 64,   // cycles per acquisition window
    parameter int BinOffset = 16,
    parameter int BinShift  = 2
) (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   sampleValid,
    input  histPkg::sample_t       sample,
    output logic                   updValid,
    output histPkg::binUpdate_t    upd,
    output logic                   resultValid,
    output histPkg::windowResult_t result
);
    import histPkg::*;

    mapped_t mapped;      // registered mapper output
    logic    rejValid;    // out-of-range sample strobe
    logic    windowEnd;   // one-cycle window close pulse

    // sample -> bin index, 1 cycle
    binMapper #(
        .BinOffset  (BinOffset),
        .BinShift   (BinShift)
    ) mapper (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .mapped      (mapped)
    );

    // bin counts, lazy clear, window timing
    histBuilder #(
        .AcqLength  (AcqLength)
    ) builder (
        .clk         (clk),
        .res         (res),
        .mapped      (mapped),
        .updValid    (updValid),
        .upd         (upd),
        .rejValid    (rejValid),
        .windowEnd   (windowEnd)
    );

    // per-window peak and totals
    peakTracker tracker (
        .clk         (clk),
        .res         (res),
        .updValid    (updValid),
        .upd         (upd),
        .rejValid    (rejValid),
        .windowEnd   (windowEnd),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

//--- verif/histTb_properties.sv
`timescale 1ns/100ps

module histTbProperties #(
    parameter int AcqLength = 64
) (
    input logic                clk,
    input logic                res,
    input logic                updValid,
    input histPkg::binUpdate_t upd,
    input logic                resultValid
);

    localparam logic [16:0] Period = 17'(AcqLength);

    logic        seenResult;    // a window has closed
    logic [16:0] sinceResult;   // cycles since the last resultValid

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            seenResult  <= 1'b0;
            sinceResult <= '0;
        end else if (resultValid) begin
            seenResult  <= 1'b1;
            sinceResult <= 17'd1;
        end else if (sinceResult != '1) begin
            sinceResult <= sinceResult + 17'd1;   // holds at all ones
        end
    end

    resultSingle: assert property (@(posedge clk) disable iff (!res)
        resultValid |=> !resultValid)
        else $error("resultValid stayed high for more than one cycle");

    // next pulse exactly one window later
    resultSpacing: assert property (@(posedge clk) disable iff (!res)
        (resultValid && seenResult) |-> (sinceResult == Period))
        else $error("window results not AcqLength cycles apart");

    resultOverdue: assert property (@(posedge clk) disable iff (!res)
        seenResult |-> (sinceResult <= Period))
        else $error("window result overdue");

    updNonzero: assert property (@(posedge clk) disable iff (!res)
        updValid |-> (upd.count != '0))
        else $error("update carries a zero count");

    updKnown: assert property (@(posedge clk) disable iff (!res)
        !$isunknown(updValid))
        else $error("updValid is unknown");

endmodule

bind histTop histTbProperties #(
    .AcqLength (AcqLength)
) props (
    .clk         (clk),
    .res         (res),
    .updValid    (updValid),
    .upd         (upd),
    .resultValid (resultValid)
);

//--- verif/histTb.sv
`timescale 1ns/100ps

module histTb;
    import histPkg::*;

    localparam int    AcqLength  = 64;
    localparam int    BinOffset  = 16;
    localparam int    BinShift   = 2;
    localparam string VectorFile = "verif/histVectors.txt";

    logic          clk;
    logic          res;
    logic          sampleValid;
    sample_t       sample;
    logic          updValid;
    binUpdate_t    upd;
    logic          resultValid;
    windowResult_t result;

    logic          stimValid [$];   // one entry per cycle
    sample_t       stimSample [$];
    binUpdate_t    expUpd [$];      // in order of arrival
    windowResult_t expRes [$];
    binUpdate_t    nextUpd;
    windowResult_t nextRes;

    int updCount;
    int resCount;
    int passCount;
    int failCount;
    int cycleCount;   // cycles since reset release
    int cycleLimit;

    histTop #(
        .AcqLength (AcqLength),
        .BinOffset (BinOffset),
        .BinShift  (BinShift)
    ) UUT (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .updValid    (updValid),
        .upd         (upd),
        .resultValid (resultValid),
        .result      (result)
    );

    always #5 clk = ~clk;   // 10 ns period

    // S lines expand to one entry per cycle, U and R lines fill the expected queues
    task automatic loadVectors(output bit ok);
        int            fd;
        int            n;
        int            a;
        int            b;
        int            c;
        int            d;
        int            i;
        bit            bad;
        string         line;
        binUpdate_t    upRec;
        windowResult_t resRec;
        bad = 1'b0;
        fd  = $fopen(VectorFile, "r");
        if (fd == 0) begin
            bad = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 1 && line[0] == "S") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%d %h %d", a, b, c);
                    if (n != 3) bad = 1'b1;
                    for (i = 0; i < c; i++) begin
                        stimValid.push_back(a != 0);
                        stimSample.push_back(sample_t'(b));
                    end
                end else if (n > 1 && line[0] == "U") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
                    if (n != 2) bad = 1'b1;
                    upRec.bin   = bin_t'(a);
                    upRec.count = count_t'(b);
                    expUpd.push_back(upRec);
                end else if (n > 1 && line[0] == "R") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d", a, b, c, d);
                    if (n != 4) bad = 1'b1;
                    resRec.peakBin   = bin_t'(a);
                    resRec.peakCount = count_t'(b);
                    resRec.hits      = hit_t'(c);
                    resRec.rejected  = hit_t'(d);
                    expRes.push_back(resRec);
                end
            end
            $fclose(fd);
        end
        ok = !bad && (stimValid.size() > 0);
    endtask

    task automatic checkUpdate(input binUpdate_t expected, input binUpdate_t actual);
        bit ok;
        ok = 1'b1;
        updCount++;
        if (actual.bin !== expected.bin) begin
            $display("Fail at %0d ns: upd.bin expected %0d, got %0d",
                     $time, expected.bin, actual.bin);
            ok = 1'b0;
        end
        if (actual.count !== expected.count) begin
            $display("Fail at %0d ns: upd.count expected %0d, got %0d",
                     $time, expected.count, actual.count);
            ok = 1'b0;
        end
        if (ok) begin
            passCount++;
            $display("update %0d: bin %0d count %0d ok", updCount, actual.bin, actual.count);
        end else begin
            failCount++;
            $display("update %0d: mismatch", updCount);
        end
    endtask

    task automatic checkResult(input windowResult_t expected, input windowResult_t actual);
        bit ok;
        ok = 1'b1;
        resCount++;
        if (actual.peakBin !== expected.peakBin) begin
            $display("Fail at %0d ns: result.peakBin expected %0d, got %0d",
                     $time, expected.peakBin, actual.peakBin);
            ok = 1'b0;
        end
        if (actual.peakCount !== expected.peakCount) begin
            $display("Fail at %0d ns: result.peakCount expected %0d, got %0d",
                     $time, expected.peakCount, actual.peakCount);
            ok = 1'b0;
        end
        if (actual.hits !== expected.hits) begin
            $display("Fail at %0d ns: result.hits expected %0d, got %0d",
                     $time, expected.hits, actual.hits);
            ok = 1'b0;
        end
        if (actual.rejected !== expected.rejected) begin
            $display("Fail at %0d ns: result.rejected expected %0d, got %0d",
                     $time, expected.rejected, actual.rejected);
            ok = 1'b0;
        end
        if (ok) begin
            passCount++;
            $display("window %0d: peak bin %0d count %0d, %0d hits, %0d rejected ok",
                     resCount, actual.peakBin, actual.peakCount, actual.hits,
                     actual.rejected);
        end else begin
            failCount++;
            $display("window %0d: mismatch", resCount);
        end
    endtask

    task automatic driveSamples();
        int i;
        i = 0;
        while (i < stimValid.size()) begin
            sampleValid <= stimValid[i];
            sample      <= stimSample[i];
            @(posedge clk);
            i++;
        end
        sampleValid <= 1'b0;
        sample      <= '0;
    endtask

    task automatic waitForDrain();
        while (expUpd.size() > 0 || expRes.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // room for a surplus update
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (res === 1'b1) begin
            if (updValid === 1'b1) begin
                if (expUpd.size() == 0) begin
                    failCount++;
                    $display("surplus update at %0d ns: bin %0d count %0d was not expected",
                             $time, upd.bin, upd.count);
                end else begin
                    nextUpd = expUpd.pop_front();
                    checkUpdate(nextUpd, upd);
                end
            end
            if (resultValid === 1'b1) begin
                if (expRes.size() == 0) begin
                    failCount++;
                    $display("surplus window result at %0d ns", $time);
                end else begin
                    nextRes = expRes.pop_front();
                    checkResult(nextRes, result);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (res === 1'b1) begin
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("Timeout after %0d cycles: %0d updates and %0d window results missing",
                         cycleCount, expUpd.size(), expRes.size());
                $display("Some tests failed");
                $finish;
            end
        end
    end

    initial begin
        bit loaded;
        clk         = 1'b0;
        res         = 1'b0;
        sampleValid = 1'b0;
        sample      = '0;
        updCount    = 0;
        resCount    = 0;
        passCount   = 0;
        failCount   = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        loadVectors(loaded);
        if (loaded) begin
            cycleLimit = stimValid.size() + 2 * AcqLength + 20;
            repeat (8) @(posedge clk);
            res <= 1'b1;   // first stimulus cycle goes out on this same edge
            driveSamples();
            waitForDrain();
        end else begin
            failCount++;
            $display("could not read the vector file %s", VectorFile);
        end
        $display("summary: %0d checks passed, %0d checks failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verif/histVectors.txt
# S lines hold valid, the sample in hex and the number of cycles it is held
# U lines hold the next expected update bin and count, R lines peakBin peakCount hits rejected
#
# window 1 gets no samples
S 0 000 63
R 0 0 0 0
#
# window 2 counts two interleaved bins to a tie at 3, checks both range edges
S 1 028 1
U 6 1
S 1 028 1
U 6 2
S 1 014 1
U 1 1
S 1 028 1
U 6 3
S 1 014 1
U 1 2
S 1 00f 1
S 1 110 1
S 1 014 1
U 1 3
S 1 3ff 1
S 1 10f 1
U 63 1
S 1 013 1
U 0 1
# sample without valid is ignored
S 0 028 3
S 0 000 50
R 6 3 8 3
#
# window 3 restarts bin 6, its last update lands on the window-end edge
S 1 028 1
U 6 1
S 1 017 1
U 1 1
S 1 017 1
U 1 2
S 0 000 59
S 1 028 1
U 6 2
S 1 028 1
U 6 3
R 6 3 5 0
#
# window 4 restarts bin 6 after that edge, one reject above range
S 1 028 1
U 6 1
S 1 200 1
S 1 018 1
U 2 1
S 0 000 61
R 6 1 2 1

//--- project.f
common/histPkg.sv
src/binMapper.sv
histBuilder/histBuilder.sv
histBuilder/peakTracker.sv
src/histTop.sv
verif/histTb_properties.sv
verif/histTb.sv

//--- run.sh
#!/bin/sh
# build and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --assert -Wno-fatal --top-module histTb -o histSim \
    -f project.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/histSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

exit 0
